//--- Bender.yml
package:
  name: arcade_io

sources:
  - include_dirs:
      - source
    files:
      - source/arcade_io_pkg.sv
      - source/key_decoder.sv
      - source/control_mapper.sv
      - source/video_output.sv
      - source/audio_dac.sv
      - source/arcade_io_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/arcade_io_assertions.sv
      - tests/arcade_io_tb.sv

//--- files.f
+incdir+source
source/arcade_io_pkg.sv
source/key_decoder.sv
source/control_mapper.sv
source/video_output.sv
source/audio_dac.sv
source/arcade_io_top.sv
tests/arcade_io_assertions.sv
tests/arcade_io_tb.sv

//--- source/arcade_io_pkg.sv
`default_nettype none

package arcade_io_pkg;

	// One PS/2 scancode byte, extended prefix already stripped
	typedef logic [7:0] key_code_t;

	// MiST joystick word
	typedef logic [7:0] joy_word_t;

	// Bit positions inside joy_word_t
	localparam int joy_right = 0;
	localparam int joy_left = 1;
	localparam int joy_down = 2;
	localparam int joy_up = 3;
	localparam int joy_fire = 4;

	// Scanline strength as set in the OSD menu
	typedef enum logic [1:0] {
		off = 2'd0,
		dim25 = 2'd1,
		dim50 = 2'd2,
		dim75 = 2'd3
	} scanline_mode_t;

	// One VGA DAC channel
	typedef logic [5:0] rgb6_t;

endpackage

`default_nettype wire

//--- source/arcade_io_settings.svh
`ifndef ARCADE_IO_SETTINGS_SVH
`define ARCADE_IO_SETTINGS_SVH

// Width of the game's audio sample
`define ARCADE_AUDIO_BITS 16

// Flip-flops in the joystick synchronizer
`define ARCADE_JOY_SYNC_STAGES 2

`endif

//--- source/arcade_io_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "arcade_io_settings.svh"

module arcade_io_top (
	input wire clock_24,
	input wire reset,
	input wire arcade_io_pkg::key_code_t key_code,
	input wire key_pressed,
	input wire key_toggle,
	input wire arcade_io_pkg::joy_word_t joystick_0,
	input wire arcade_io_pkg::joy_word_t joystick_1,
	output logic game_right_up,
	output logic game_right_down,
	output logic game_right_left,
	output logic game_right_right,
	output logic game_left_up,
	output logic game_left_down,
	output logic game_left_left,
	output logic game_left_right,
	output logic game_fire,
	output logic game_coin,
	output logic game_start1,
	output logic game_start2,
	input wire pixel_enable,
	input wire [2:0] red,
	input wire [2:0] green,
	input wire [1:0] blue,
	input wire hblank,
	input wire vblank,
	input wire hsync,
	input wire vsync,
	input wire arcade_io_pkg::scanline_mode_t scanlines,
	input wire scandouble_off,
	output arcade_io_pkg::rgb6_t vga_r,
	output arcade_io_pkg::rgb6_t vga_g,
	output arcade_io_pkg::rgb6_t vga_b,
	output logic vga_hs,
	output logic vga_vs,
	input wire [`ARCADE_AUDIO_BITS-1:0] audio,
	output logic audio_l,
	output logic audio_r
);

	logic right_up, right_down, right_left, right_right;
	logic left_up, left_down, left_left, left_right;
	logic coin, start1, start2;
	logic fire1, fire2, fire3;

	key_decoder key_decoder0 (
		.clock_24(clock_24), .reset(reset),
		.key_code(key_code), .key_pressed(key_pressed), .key_toggle(key_toggle),
		.right_up(right_up), .right_down(right_down),
		.right_left(right_left), .right_right(right_right),
		.left_up(left_up), .left_down(left_down),
		.left_left(left_left), .left_right(left_right),
		.coin(coin), .start1(start1), .start2(start2),
		.fire1(fire1), .fire2(fire2), .fire3(fire3)
	);

	control_mapper control_mapper0 (
		.clock_24(clock_24), .reset(reset),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.right_up(right_up), .right_down(right_down),
		.right_left(right_left), .right_right(right_right),
		.left_up(left_up), .left_down(left_down),
		.left_left(left_left), .left_right(left_right),
		.coin(coin), .start1(start1), .start2(start2),
		.fire1(fire1), .fire2(fire2), .fire3(fire3),
		.game_right_up(game_right_up), .game_right_down(game_right_down),
		.game_right_left(game_right_left), .game_right_right(game_right_right),
		.game_left_up(game_left_up), .game_left_down(game_left_down),
		.game_left_left(game_left_left), .game_left_right(game_left_right),
		.game_fire(game_fire), .game_coin(game_coin),
		.game_start1(game_start1), .game_start2(game_start2)
	);

	video_output video_output0 (
		.clock_24(clock_24), .reset(reset), .pixel_enable(pixel_enable),
		.red(red), .green(green), .blue(blue),
		.hblank(hblank), .vblank(vblank), .hsync(hsync), .vsync(vsync),
		.scanlines(scanlines), .scandouble_off(scandouble_off),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs)
	);

	audio_dac #(
		.AUDIO_BITS(`ARCADE_AUDIO_BITS),
		.INVERT_MSB(1'b1) // Game sample is signed
	) audio_dac0 (
		.clock_24(clock_24),
		.reset(reset),
		.sample(audio),
		.audio_out(audio_l)
	);

	assign audio_r = audio_l; // Mono on both jacks

endmodule

`default_nettype wire

//--- source/audio_dac.sv
`timescale 1ns/1ns
`default_nettype none
`include "arcade_io_settings.svh"

module audio_dac #(
	parameter int AUDIO_BITS = `ARCADE_AUDIO_BITS,
	parameter bit INVERT_MSB = 1'b1
) (
	input wire clock_24,
	input wire reset,
	input wire [AUDIO_BITS-1:0] sample,
	output logic audio_out
);

	logic [AUDIO_BITS-1:0] level;
	logic [AUDIO_BITS:0] accumulator;

	// Signed to offset binary
	always_comb begin
		level = sample;
		if (INVERT_MSB) begin
			level[AUDIO_BITS-1] = ~sample[AUDIO_BITS-1];
		end
	end

	// Top bit is the carry of the last add, dropped before the next one
	always_ff @(posedge clock_24) begin
		if (reset) begin
			accumulator <= '0;
		end else begin
			accumulator <= {1'b0, accumulator[AUDIO_BITS-1:0]} + {1'b0, level};
		end
	end

	assign audio_out = accumulator[AUDIO_BITS];

endmodule

`default_nettype wire

//--- source/control_mapper.sv
`timescale 1ns/1ns
`default_nettype none
`include "arcade_io_settings.svh"

module control_mapper (
	input wire clock_24,
	input wire reset,
	input wire arcade_io_pkg::joy_word_t joystick_0,
	input wire arcade_io_pkg::joy_word_t joystick_1,
	input wire right_up,
	input wire right_down,
	input wire right_left,
	input wire right_right,
	input wire left_up,
	input wire left_down,
	input wire left_left,
	input wire left_right,
	input wire coin,
	input wire start1,
	input wire start2,
	input wire fire1,
	input wire fire2, // Held for cores with more buttons
	input wire fire3,
	output logic game_right_up,
	output logic game_right_down,
	output logic game_right_left,
	output logic game_right_right,
	output logic game_left_up,
	output logic game_left_down,
	output logic game_left_left,
	output logic game_left_right,
	output logic game_fire,
	output logic game_coin,
	output logic game_start1,
	output logic game_start2
);

	localparam int sync_stages = `ARCADE_JOY_SYNC_STAGES;

	arcade_io_pkg::joy_word_t joy0_sync [sync_stages];
	arcade_io_pkg::joy_word_t joy1_sync [sync_stages];
	arcade_io_pkg::joy_word_t joy0;
	arcade_io_pkg::joy_word_t joy1;

	assign joy0 = joy0_sync[sync_stages-1];
	assign joy1 = joy1_sync[sync_stages-1];

	always_ff @(posedge clock_24) begin
		if (reset) begin
			for (int i = 0; i < sync_stages; i++) begin
				joy0_sync[i] <= '0;
				joy1_sync[i] <= '0;
			end
		end else begin
			joy0_sync[0] <= joystick_0;
			joy1_sync[0] <= joystick_1;
			for (int i = 1; i < sync_stages; i++) begin
				joy0_sync[i] <= joy0_sync[i-1];
				joy1_sync[i] <= joy1_sync[i-1];
			end
		end
	end

	always_ff @(posedge clock_24) begin
		if (reset) begin
			game_right_up <= 1'b0;
			game_right_down <= 1'b0;
			game_right_left <= 1'b0;
			game_right_right <= 1'b0;
			game_left_up <= 1'b0;
			game_left_down <= 1'b0;
			game_left_left <= 1'b0;
			game_left_right <= 1'b0;
			game_fire <= 1'b0;
			game_coin <= 1'b0;
			game_start1 <= 1'b0;
			game_start2 <= 1'b0;
		end else begin
			// Right stick shares arrows and joystick 0
			game_right_up <= right_up | joy0[arcade_io_pkg::joy_up];
			game_right_down <= right_down | joy0[arcade_io_pkg::joy_down];
			game_right_left <= right_left | joy0[arcade_io_pkg::joy_left];
			game_right_right <= right_right | joy0[arcade_io_pkg::joy_right];
			game_left_up <= left_up | joy1[arcade_io_pkg::joy_up];
			game_left_down <= left_down | joy1[arcade_io_pkg::joy_down];
			game_left_left <= left_left | joy1[arcade_io_pkg::joy_left];
			game_left_right <= left_right | joy1[arcade_io_pkg::joy_right];
			game_fire <= fire1 | joy0[arcade_io_pkg::joy_fire] |
				joy1[arcade_io_pkg::joy_fire];
			game_coin <= coin;
			game_start1 <= start1;
			game_start2 <= start2;
		end
	end

endmodule

`default_nettype wire

//--- source/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input wire clock_24,
	input wire reset,
	input wire arcade_io_pkg::key_code_t key_code,
	input wire key_pressed,
	input wire key_toggle,
	output logic right_up,
	output logic right_down,
	output logic right_left,
	output logic right_right,
	output logic left_up,
	output logic left_down,
	output logic left_left,
	output logic left_right,
	output logic coin,
	output logic start1,
	output logic start2,
	output logic fire1,
	output logic fire2,
	output logic fire3
);

	logic toggle_sampled;
	logic toggle_previous;
	logic key_event;

	// Change of the sampled toggle marks one key event
	assign key_event = toggle_sampled != toggle_previous;

	always_ff @(posedge clock_24) begin
		if (reset) begin
			toggle_sampled <= 1'b0;
			toggle_previous <= 1'b0;
		end else begin
			toggle_sampled <= key_toggle;
			toggle_previous <= toggle_sampled;
		end
	end

	always_ff @(posedge clock_24) begin
		if (reset) begin
			right_up <= 1'b0;
			right_down <= 1'b0;
			right_left <= 1'b0;
			right_right <= 1'b0;
			left_up <= 1'b0;
			left_down <= 1'b0;
			left_left <= 1'b0;
			left_right <= 1'b0;
			coin <= 1'b0;
			start1 <= 1'b0;
			start2 <= 1'b0;
			fire1 <= 1'b0;
			fire2 <= 1'b0;
			fire3 <= 1'b0;
		end else if (key_event) begin
			case (key_code)
				8'h75: right_up <= key_pressed; // Arrow up
				8'h72: right_down <= key_pressed; // Arrow down
				8'h6b: right_left <= key_pressed; // Arrow left
				8'h74: right_right <= key_pressed; // Arrow right
				8'h1d: left_up <= key_pressed; // W
				8'h1b: left_down <= key_pressed; // S
				8'h1c: left_left <= key_pressed; // A
				8'h23: left_right <= key_pressed; // D
				8'h76: coin <= key_pressed; // ESC
				8'h05: start1 <= key_pressed; // F1
				8'h06: start2 <= key_pressed; // F2
				8'h29: fire1 <= key_pressed; // Space
				8'h11: fire2 <= key_pressed; // Alt
				8'h14: fire3 <= key_pressed; // Ctrl
				default: ; // Other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/video_output.sv
`timescale 1ns/1ns
`default_nettype none

module video_output (
	input wire clock_24,
	input wire reset,
	input wire pixel_enable,
	input wire [2:0] red,
	input wire [2:0] green,
	input wire [1:0] blue,
	input wire hblank,
	input wire vblank,
	input wire hsync,
	input wire vsync,
	input wire arcade_io_pkg::scanline_mode_t scanlines,
	input wire scandouble_off,
	output arcade_io_pkg::rgb6_t vga_r,
	output arcade_io_pkg::rgb6_t vga_g,
	output arcade_io_pkg::rgb6_t vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	logic line_odd;
	logic hsync_previous;
	logic blank;
	logic dim_active;
	arcade_io_pkg::rgb6_t red_wide;
	arcade_io_pkg::rgb6_t green_wide;
	arcade_io_pkg::rgb6_t blue_wide;
	arcade_io_pkg::rgb6_t red_next;
	arcade_io_pkg::rgb6_t green_next;
	arcade_io_pkg::rgb6_t blue_next;

	// Subtract the truncated fraction picked by the mode
	function automatic arcade_io_pkg::rgb6_t dim_channel(
		input arcade_io_pkg::rgb6_t value,
		input arcade_io_pkg::scanline_mode_t mode
	);
		logic [7:0] triple;
		triple = {2'b00, value} * 8'd3;
		case (mode)
			arcade_io_pkg::dim25: dim_channel = value - (value >> 2);
			arcade_io_pkg::dim50: dim_channel = value - (value >> 1);
			arcade_io_pkg::dim75: dim_channel = value - triple[7:2];
			default: dim_channel = value;
		endcase
	endfunction

	// Bit repetition keeps full white at 63
	assign red_wide = {red, red};
	assign green_wide = {green, green};
	assign blue_wide = {blue, blue, blue};

	assign blank = hblank | vblank;
	assign dim_active = line_odd & ~scandouble_off;

	always_comb begin
		if (blank) begin
			red_next = '0;
			green_next = '0;
			blue_next = '0;
		end else if (dim_active) begin
			red_next = dim_channel(red_wide, scanlines);
			green_next = dim_channel(green_wide, scanlines);
			blue_next = dim_channel(blue_wide, scanlines);
		end else begin
			red_next = red_wide;
			green_next = green_wide;
			blue_next = blue_wide;
		end
	end

	always_ff @(posedge clock_24) begin
		if (reset) begin
			line_odd <= 1'b0;
			hsync_previous <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (pixel_enable) begin
			hsync_previous <= hsync;
			if (hsync && !hsync_previous) begin
				line_odd <= ~line_odd; // New line starts
			end
			vga_r <= red_next;
			vga_g <= green_next;
			vga_b <= blue_next;
			vga_hs <= hsync; // Same delay as colour
			vga_vs <= vsync;
		end
	end

endmodule

`default_nettype wire

//--- tests/arcade_io_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module arcade_io_assertions (
	input wire clock_24,
	input wire reset,
	input wire game_right_up,
	input wire game_right_down,
	input wire game_right_left,
	input wire game_right_right,
	input wire game_left_up,
	input wire game_left_down,
	input wire game_left_left,
	input wire game_left_right,
	input wire game_fire,
	input wire game_coin,
	input wire game_start1,
	input wire game_start2,
	input wire pixel_enable,
	input wire hblank,
	input wire vblank,
	input wire arcade_io_pkg::rgb6_t vga_r,
	input wire arcade_io_pkg::rgb6_t vga_g,
	input wire arcade_io_pkg::rgb6_t vga_b,
	input wire vga_hs,
	input wire vga_vs,
	input wire audio_l,
	input wire audio_r
);

	logic [11:0] game_controls;
	int failure_count = 0;

	assign game_controls = {game_right_up, game_right_down, game_right_left, game_right_right,
		game_left_up, game_left_down, game_left_left, game_left_right,
		game_fire, game_coin, game_start1, game_start2};

	reset_clears_outputs: assert property (@(posedge clock_24)
		reset |=> (game_controls == '0 && !vga_hs && !vga_vs && !audio_l && !audio_r))
		else begin
			failure_count++;
			$error("Game controls, VGA syncs or audio not cleared by reset");
		end

	// Video path only moves on 6 MHz enable cycles
	video_holds_when_idle: assert property (@(posedge clock_24) disable iff (reset)
		!pixel_enable |=> $stable({vga_r, vga_g, vga_b, vga_hs, vga_vs}))
		else begin
			failure_count++;
			$error("VGA outputs changed after a cycle without pixel_enable");
		end

	blank_gives_black: assert property (@(posedge clock_24) disable iff (reset)
		pixel_enable && (hblank || vblank) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin
			failure_count++;
			$error("Blanked pixel produced a non-zero colour");
		end

endmodule

bind arcade_io_top arcade_io_assertions assertions0 (.*);

`default_nettype wire

//--- tests/arcade_io_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "arcade_io_settings.svh"

module arcade_io_tb;

	typedef struct packed {
		arcade_io_pkg::key_code_t code;
		logic pressed;
		logic toggle;
		arcade_io_pkg::joy_word_t joy0;
		arcade_io_pkg::joy_word_t joy1;
		logic [11:0] expected; // Right stick, left stick, fire, coin, start1, start2
	} control_step_t;

	localparam int step_count = 40;
	localparam int pixels_per_mode = 24;
	localparam int video_cycles = 8 * pixels_per_mode * 4;
	localparam int density_cycles = 4096;
	localparam int dac_cycles = 4 * (16 + density_cycles);
	localparam int cycle_limit = 3 + step_count * 3 + video_cycles + dac_cycles + 256;

	logic clock_24;
	logic reset;
	arcade_io_pkg::key_code_t key_code;
	logic key_pressed;
	logic key_toggle;
	arcade_io_pkg::joy_word_t joystick_0;
	arcade_io_pkg::joy_word_t joystick_1;
	logic game_right_up, game_right_down, game_right_left, game_right_right;
	logic game_left_up, game_left_down, game_left_left, game_left_right;
	logic game_fire, game_coin, game_start1, game_start2;
	logic pixel_enable;
	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;
	logic hblank, vblank, hsync, vsync;
	arcade_io_pkg::scanline_mode_t scanlines;
	logic scandouble_off;
	arcade_io_pkg::rgb6_t vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs;
	logic [`ARCADE_AUDIO_BITS-1:0] audio;
	logic audio_l, audio_r;

	logic [11:0] game_controls;
	logic [31:0] lcg_state;
	logic model_line_odd;
	logic model_hsync_previous;
	int cycle_count = 0;

	string control_names [12] = '{"game_right_up", "game_right_down", "game_right_left",
		"game_right_right", "game_left_up", "game_left_down", "game_left_left",
		"game_left_right", "game_fire", "game_coin", "game_start1", "game_start2"};

	control_step_t steps [step_count] = '{
		{8'h75, 1'b1, 1'b1, 8'h00, 8'h00, 12'b1000_0000_0000}, // Arrow keys
		{8'h75, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h72, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0100_0000_0000},
		{8'h72, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h6b, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0010_0000_0000},
		{8'h6b, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h74, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0001_0000_0000},
		{8'h74, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h1d, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_1000_0000}, // W A S D
		{8'h1d, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h1b, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0100_0000},
		{8'h1b, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h1c, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0010_0000},
		{8'h1c, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h23, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0001_0000},
		{8'h23, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h76, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0100}, // ESC, F1, F2, Space
		{8'h76, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h05, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0010},
		{8'h05, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h06, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0001},
		{8'h06, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h29, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0000_1000},
		{8'h29, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h75, 1'b1, 1'b0, 8'h00, 8'h00, 12'b0000_0000_0000}, // No toggle, no event
		{8'h2a, 1'b1, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000}, // Unlisted key
		{8'h00, 1'b0, 1'b0, 8'h09, 8'h00, 12'b1001_0000_0000}, // Joystick directions
		{8'h00, 1'b0, 1'b0, 8'h06, 8'h00, 12'b0110_0000_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h09, 12'b0000_1001_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h06, 12'b0000_0110_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h10, 12'b0000_0000_1000}, // Fire from either stick
		{8'h00, 1'b0, 1'b0, 8'h10, 8'h00, 12'b0000_0000_1000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h75, 1'b1, 1'b1, 8'h08, 8'h00, 12'b1000_0000_0000}, // Key and stick together
		{8'h75, 1'b0, 1'b1, 8'h08, 8'h00, 12'b1000_0000_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h00, 12'b0000_0000_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h08, 12'b0000_1000_0000},
		{8'h1d, 1'b1, 1'b1, 8'h00, 8'h08, 12'b0000_1000_0000},
		{8'h00, 1'b0, 1'b0, 8'h00, 8'h00, 12'b0000_1000_0000},
		{8'h1d, 1'b0, 1'b1, 8'h00, 8'h00, 12'b0000_0000_0000}
	};

	assign game_controls = {game_right_up, game_right_down, game_right_left, game_right_right,
		game_left_up, game_left_down, game_left_left, game_left_right,
		game_fire, game_coin, game_start1, game_start2};

	arcade_io_top dut0 (.*);

	initial begin
		clock_24 = 1'b0;
		forever #4 clock_24 = ~clock_24;
	end

	always @(posedge clock_24) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	always @(negedge clock_24) begin
		if (dut0.assertions0.failure_count != 0) begin
			$display("A bound assertion on the DUT failed");
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic logic [7:0] random_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// Expected channel after blanking and scanline dimming
	function automatic arcade_io_pkg::rgb6_t dimmed(input logic blank, input logic dim,
			input arcade_io_pkg::scanline_mode_t mode, input arcade_io_pkg::rgb6_t wide);
		int v;
		v = wide;
		if (blank) begin
			return '0;
		end
		if (!dim) begin
			return wide;
		end
		case (mode)
			arcade_io_pkg::dim25: return arcade_io_pkg::rgb6_t'(v - v / 4);
			arcade_io_pkg::dim50: return arcade_io_pkg::rgb6_t'(v - v / 2);
			arcade_io_pkg::dim75: return arcade_io_pkg::rgb6_t'(v - (3 * v) / 4);
			default: return wide;
		endcase
	endfunction

	task automatic check_control(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_rgb(input string name, input arcade_io_pkg::rgb6_t actual,
			input arcade_io_pkg::rgb6_t expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_density(input string name, input int count, input int low,
			input int high);
		if (count < low || count > high) begin
			$display("ERR %s: ones count %h, expected %h to %h", name, count, low, high);
			abort_run();
		end
	endtask

	task automatic check_reset_state();
		for (int i = 0; i < 12; i++) begin
			check_control(control_names[i], game_controls[11 - i], 1'b0);
		end
		check_rgb("vga_r", vga_r, '0);
		check_rgb("vga_g", vga_g, '0);
		check_rgb("vga_b", vga_b, '0);
		check_control("vga_hs", vga_hs, 1'b0);
		check_control("vga_vs", vga_vs, 1'b0);
		check_control("audio_l", audio_l, 1'b0);
	endtask

	task automatic run_control_steps();
		for (int s = 0; s < step_count; s++) begin
			key_code = steps[s].code;
			key_pressed = steps[s].pressed;
			if (steps[s].toggle) begin
				key_toggle = ~key_toggle;
			end
			joystick_0 = steps[s].joy0;
			joystick_1 = steps[s].joy1;
			repeat (3) @(posedge clock_24); // Toggle to control output
			@(negedge clock_24);
			for (int i = 0; i < 12; i++) begin
				check_control(control_names[i], game_controls[11 - i], steps[s].expected[11 - i]);
			end
		end
	endtask

	// One enabled pixel followed by three idle cycles
	task automatic send_pixel();
		logic [7:0] pick;
		logic dim;
		arcade_io_pkg::rgb6_t expected_r;
		arcade_io_pkg::rgb6_t expected_g;
		arcade_io_pkg::rgb6_t expected_b;
		logic expected_hs;
		logic expected_vs;
		pick = random_byte();
		red = pick[2:0];
		green = pick[5:3];
		blue = pick[7:6];
		pick = random_byte();
		hblank = pick[2:0] == 3'd0;
		vblank = pick[5:3] == 3'd0;
		hsync = pick[6];
		vsync = pick[7];
		pixel_enable = 1'b1;
		dim = model_line_odd & ~scandouble_off;
		expected_r = dimmed(hblank | vblank, dim, scanlines, {red, red});
		expected_g = dimmed(hblank | vblank, dim, scanlines, {green, green});
		expected_b = dimmed(hblank | vblank, dim, scanlines, {blue, blue, blue});
		expected_hs = hsync;
		expected_vs = vsync;
		if (hsync && !model_hsync_previous) begin
			model_line_odd = ~model_line_odd;
		end
		model_hsync_previous = hsync;
		@(negedge clock_24);
		pixel_enable = 1'b0;
		repeat (3) begin
			pick = random_byte();
			red = pick[2:0]; // Must not reach the outputs
			green = pick[5:3];
			blue = pick[7:6];
			@(negedge clock_24);
		end
		check_rgb("vga_r", vga_r, expected_r);
		check_rgb("vga_g", vga_g, expected_g);
		check_rgb("vga_b", vga_b, expected_b);
		check_control("vga_hs", vga_hs, expected_hs);
		check_control("vga_vs", vga_vs, expected_vs);
	endtask

	task automatic run_video();
		for (int mode = 0; mode < 8; mode++) begin
			scanlines = arcade_io_pkg::scanline_mode_t'(mode[1:0]);
			scandouble_off = mode[2];
			for (int p = 0; p < pixels_per_mode; p++) begin
				send_pixel();
			end
		end
	endtask

	task automatic run_audio();
		logic [`ARCADE_AUDIO_BITS-1:0] samples [4];
		longint full_scale;
		longint scaled;
		int ones;
		int ones_r;
		int low;
		int high;
		samples = '{16'h8000, 16'h0000, 16'h4000, 16'h7fff};
		full_scale = longint'(1) << `ARCADE_AUDIO_BITS;
		foreach (samples[i]) begin
			audio = samples[i];
			scaled = (samples[i] ^ (full_scale >> 1)) * density_cycles; // Offset binary
			low = int'((scaled > full_scale) ? (scaled - 1) / full_scale : 0);
			high = int'((scaled + full_scale) / full_scale);
			repeat (16) @(negedge clock_24);
			ones = 0;
			ones_r = 0;
			repeat (density_cycles) begin
				@(negedge clock_24);
				ones = ones + int'(audio_l);
				ones_r = ones_r + int'(audio_r);
			end
			check_density("audio_l", ones, low, high);
			check_density("audio_r", ones_r, low, high);
		end
	endtask

	initial begin
		lcg_state = 32'd23947;
		reset = 1'b1;
		key_code = '0;
		key_pressed = 1'b0;
		key_toggle = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		pixel_enable = 1'b0;
		red = '0;
		green = '0;
		blue = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		scanlines = arcade_io_pkg::off;
		scandouble_off = 1'b0;
		audio = 1 << (`ARCADE_AUDIO_BITS - 1); // Zero level after sign flip
		model_line_odd = 1'b0;
		model_hsync_previous = 1'b0;
		repeat (3) @(negedge clock_24);
		reset = 1'b0;
		check_reset_state();
		run_control_steps();
		run_video();
		run_audio();
		if (dut0.assertions0.failure_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("A bound assertion on the DUT failed");
			abort_run();
		end
	end

endmodule

`default_nettype wire
